// File: Makefile
TOP = tb_ads_top

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// File: all.f
+incdir+rtl
rtl/ads_reg_pkg.sv
rtl/ads_link_pkg.sv
rtl/ads_spi.sv
rtl/ads_ctrl.sv
rtl/ads_top.sv
dv/ads_adc_model.sv
dv/tb_ads_top.sv

// File: dv/ads_adc_model.sv
`include "ads_cfg.svh"

module ads_adc_model #(
    parameter int MAX_GAP = 40
) (
    input  logic clk,
    input  logic cs,
    input  logic sclk,
    input  logic mosi,
    output logic miso
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MSB = `ADS_WORD_BITS - 1;

    logic [MSB:0] conv_q[$];   // conversions still to be returned
    logic [MSB:0] frame_q[$];  // every word written over mosi
    int           rise_q[$];   // sclk rising edges seen per frame
    int           stray_edges = 0;

    integer       seed;
    logic [MSB:0] next_word;

    initial begin : frame_loop
        logic [MSB:0] tx;
        logic [MSB:0] rx;
        int           rises;
        int           gap;
        integer       r;
        seed      = 32'h171f5b2e;
        next_word = '1;  // config frame reads back all ones
        miso      = 1'b1;
        forever begin
            @(negedge cs);
            tx        = next_word;
            next_word = '1;
            rx        = '0;
            rises     = 0;
            while (cs === 1'b0) begin
                @(posedge sclk or negedge sclk or posedge cs);
                if (cs === 1'b0 && sclk === 1'b1) begin
                    miso  = tx[MSB];  // mode 1 device drives on rising sclk
                    tx    = {tx[MSB-1:0], 1'b0};
                    rises = rises + 1;
                end else if (cs === 1'b0) begin
                    rx = {rx[MSB-1:0], mosi};
                end
            end
            miso = 1'b1;  // not ready until the next conversion
            frame_q.push_back(rx);
            rise_q.push_back(rises);
            if (conv_q.size() > 0) begin
                r   = $random(seed);
                gap = 1 + int'((r & 32'h7fffffff) % MAX_GAP);
                repeat (gap) @(negedge clk);
                next_word = conv_q.pop_front();
                miso      = 1'b0;  // data-ready
            end
        end
    end

    always @(posedge sclk) begin
        if (cs) begin
            stray_edges++;  // clock outside a cs-low window
        end
    end

endmodule

// File: dv/tb_ads_top.sv
`include "ads_cfg.svh"

module tb_ads_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 4;
    localparam int N_CONV       = 20;  // queued conversions, echo word included
    localparam int ECHO_AT      = 6;
    localparam int MAX_GAP      = 40;
    localparam int MAX_STALL    = 12;
    localparam int FRAME_CYCLES = 1 + 34 * `ADS_SCLK_DIV;
    localparam int LIMIT_CYCLES = `ADS_POWERUP_CYCLES +
                                  (N_CONV + 1) * (FRAME_CYCLES + MAX_GAP + MAX_STALL + 8) + 200;

    logic                             clk;
    logic                             rst;
    logic [2:0]                       cfg_mux;
    logic [2:0]                       cfg_pga;
    logic [2:0]                       cfg_dr;
    logic                             miso;
    logic                             mosi;
    logic                             sclk;
    logic                             cs;
    logic signed [`ADS_WORD_BITS-1:0] sample_data;
    logic                             sample_valid;
    logic                             sample_ready;

    integer                           seed;
    ads_reg_pkg::ads_word_u           cfg_valid;  // expected first frame
    ads_reg_pkg::ads_word_u           cfg_none;   // expected on every read
    logic signed [`ADS_WORD_BITS-1:0] exp_q[$];
    logic signed [`ADS_WORD_BITS-1:0] held_data;
    logic                             pending;
    logic                             cs_seen;
    int                               stall_left;
    int                               n_expect;
    int                               n_taken;
    int                               n_frames;
    int                               cycles;

    ads_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .cfg_mux      (cfg_mux),
        .cfg_pga      (cfg_pga),
        .cfg_dr       (cfg_dr),
        .miso         (miso),
        .mosi         (mosi),
        .sclk         (sclk),
        .cs           (cs),
        .sample_data  (sample_data),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready)
    );

    ads_adc_model #(.MAX_GAP(MAX_GAP)) adc_i (
        .clk  (clk),
        .cs   (cs),
        .sclk (sclk),
        .mosi (mosi),
        .miso (miso)
    );

    // ======================================================================
    // reference and compare helpers
    // ======================================================================

    // ss, mux, pga, mode, dr, ts, pull-up, nop, reserved
    function automatic ads_reg_pkg::ads_word_u expected_cfg(input logic [2:0] mux,
            input logic [2:0] pga, input logic [2:0] dr, input ads_reg_pkg::ads_nop_e nop);
        expected_cfg = {1'b0, mux, pga, 1'b0, dr, 1'b0, 1'b1, nop, 1'b1};
    endfunction

    function automatic int rand_below(input int n);
        integer r;
        r = $random(seed);
        return int'((r & 32'h7fffffff) % n);
    endfunction

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input ads_reg_pkg::ads_word_u want,
            input ads_reg_pkg::ads_word_u got);
        if (got !== want) begin
            $display("FAIL %s expected %h actual %h", name, want, got);
            abort_run();
        end
    endtask

    task automatic check_sample(input string name, input logic signed [`ADS_WORD_BITS-1:0] want,
            input logic signed [`ADS_WORD_BITS-1:0] got);
        if (got !== want) begin
            $display("FAIL %s expected %0d actual %0d", name, want, got);
            abort_run();
        end
    endtask

    // ======================================================================
    // clock, stimulus and end of run
    // ======================================================================

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : main_seq
        logic signed [`ADS_WORD_BITS-1:0] conv;
        seed         = 32'h171f5b2e;
        rst          = 1'b1;
        cfg_mux      = 3'b011;
        cfg_pga      = 3'b001;
        cfg_dr       = 3'b100;
        sample_ready = 1'b0;
        pending      = 1'b0;
        cs_seen      = 1'b0;
        stall_left   = 0;
        n_taken      = 0;
        n_frames     = 0;
        cycles       = 0;
        cfg_valid    = expected_cfg(cfg_mux, cfg_pga, cfg_dr, ads_reg_pkg::NOP_VALID);
        cfg_none     = expected_cfg(cfg_mux, cfg_pga, cfg_dr, ads_reg_pkg::NOP_NONE);
        for (int i = 0; i < N_CONV; i++) begin
            case (i)
                0:       conv = 16'sh8000;  // full-scale negative
                1:       conv = 16'sh7fff;
                2:       conv = -16'sd1;
                ECHO_AT: conv = cfg_valid.conv;  // device echoing its config
                default: conv = 16'(rand_below(65536));
            endcase
            adc_i.conv_q.push_back(conv);
            if (conv !== cfg_valid.conv) begin
                exp_q.push_back(conv);
            end
        end
        n_expect = exp_q.size();
        repeat (2) @(negedge clk);
        if (cs !== 1'b1 || sclk !== 1'b0 || mosi !== 1'b0 || sample_valid !== 1'b0) begin
            $display({"FAIL reset state expected cs 1 sclk 0 mosi 0 sample_valid 0",
                      " actual cs %b sclk %b mosi %b sample_valid %b"},
                     cs, sclk, mosi, sample_valid);
            abort_run();
        end
        rst <= 1'b0;
        wait (n_taken == n_expect);
        repeat (FRAME_CYCLES) @(negedge clk);  // room for an unwanted extra frame
        if (n_frames == N_CONV + 1 && adc_i.frame_q.size() == N_CONV + 1) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("FAIL frame count expected %0d actual %0d", N_CONV + 1,
                     adc_i.frame_q.size());
            abort_run();
        end
    end

    initial begin : watchdog
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("samples stopped arriving, %0d of %0d taken after %0d cycles",
                 n_taken, n_expect, LIMIT_CYCLES);
        abort_run();
    end

    // ======================================================================
    // checkers
    // ======================================================================

    always @(negedge clk) begin : frame_check
        if (!rst) begin
            cycles++;
            if (!cs && !cs_seen) begin
                cs_seen = 1'b1;
                // power-up wait, then one cycle from xfer_start to cs low
                if (cycles != `ADS_POWERUP_CYCLES + 1) begin
                    $display("FAIL first frame start expected cycle %0d actual cycle %0d",
                             `ADS_POWERUP_CYCLES + 1, cycles);
                    abort_run();
                end
            end
            if (adc_i.frame_q.size() > n_frames) begin
                if (n_frames == 0) begin
                    check_word("config write", cfg_valid, adc_i.frame_q[0]);
                end else begin
                    check_word($sformatf("read frame %0d", n_frames), cfg_none,
                               adc_i.frame_q[n_frames]);
                end
                if (adc_i.rise_q[n_frames] != `ADS_WORD_BITS) begin
                    $display("FAIL frame %0d sclk rising edges expected %0d actual %0d",
                             n_frames, `ADS_WORD_BITS, adc_i.rise_q[n_frames]);
                    abort_run();
                end
                n_frames++;
            end
            if (adc_i.stray_edges != 0) begin
                $display("sclk toggled while cs was high");
                abort_run();
            end
        end
    end

    // drives sample_ready and compares every accepted sample
    always @(negedge clk) begin : host_port
        if (!rst) begin
            if (pending) begin
                if (!sample_valid) begin
                    $display("sample_valid dropped before the host took the sample");
                    abort_run();
                end
                check_sample("held sample", held_data, sample_data);
            end
            if (sample_valid && !pending) begin
                stall_left = rand_below(MAX_STALL + 1);  // new sample, pick a stall
            end
            sample_ready = (stall_left == 0);
            if (stall_left > 0) begin
                stall_left--;
            end
            if (sample_valid && sample_ready) begin
                if (exp_q.size() == 0) begin
                    $display("more samples presented than conversions queued");
                    abort_run();
                end
                check_sample($sformatf("sample %0d", n_taken), exp_q.pop_front(), sample_data);
                n_taken++;
                pending = 1'b0;
            end else begin
                pending   = sample_valid;
                held_data = sample_data;
            end
            if (!cs && sample_valid) begin
                $display("frame started while a sample was held");
                abort_run();
            end
        end
    end

endmodule

// File: rtl/ads_cfg.svh
`ifndef ADS_CFG_SVH
`define ADS_CFG_SVH

// system clocks per sclk half period
`define ADS_SCLK_DIV 4

// wait after reset before the first frame, kept short for simulation
`define ADS_POWERUP_CYCLES 64

// spi frame length
`define ADS_WORD_BITS 16

`endif

// File: rtl/ads_ctrl.sv
`include "ads_cfg.svh"

module ads_ctrl (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [2:0]                       cfg_mux,
    input  logic [2:0]                       cfg_pga,
    input  logic [2:0]                       cfg_dr,
    input  logic                             miso,
    input  logic                             cs,
    output logic                             xfer_start,
    output logic [`ADS_WORD_BITS-1:0]        tx_word,
    input  logic                             xfer_done,
    input  logic [`ADS_WORD_BITS-1:0]        rx_word,
    output logic signed [`ADS_WORD_BITS-1:0] sample_data,
    output logic                             sample_valid,
    input  logic                             sample_ready
);

    localparam int PWR_W = (`ADS_POWERUP_CYCLES > 1) ? $clog2(`ADS_POWERUP_CYCLES) : 1;

    ads_link_pkg::ctrl_state_e state;

    logic [PWR_W-1:0] pwr_cnt;

    ads_reg_pkg::ads_word_u init_word;  // built from host codes
    ads_reg_pkg::ads_word_u cfg_word;   // initial config as written
    ads_reg_pkg::ads_word_u read_word;
    ads_reg_pkg::ads_word_u rx_view;

    logic pwr_done;
    logic drdy;
    logic read_end;
    logic rx_echo;
    logic take;

    // ======================================================================
    // word assembly and decode
    // ======================================================================

    always_comb begin
        init_word.cfg.ss         = ads_reg_pkg::SS_NONE;
        init_word.cfg.mux        = cfg_mux;
        init_word.cfg.pga        = cfg_pga;
        init_word.cfg.mode       = ads_reg_pkg::MODE_CONTINUOUS;
        init_word.cfg.dr         = cfg_dr;
        init_word.cfg.ts_mode    = ads_reg_pkg::TS_ADC;
        init_word.cfg.pull_up_en = ads_reg_pkg::PULLUP_ON;
        init_word.cfg.nop        = ads_reg_pkg::NOP_VALID;
        init_word.cfg.reserved   = ads_reg_pkg::RSV_ONE;
    end

    // reads resend the same config without updating it
    always_comb begin
        read_word         = cfg_word;
        read_word.cfg.nop = ads_reg_pkg::NOP_NONE;
    end

    assign rx_view = rx_word;
    assign rx_echo = (rx_view.cfg == cfg_word.cfg);  // device echoing its config

    assign pwr_done = (state == ads_link_pkg::ST_POWERUP) &&
                      (pwr_cnt == PWR_W'(`ADS_POWERUP_CYCLES - 1));
    assign drdy     = (state == ads_link_pkg::ST_WATCH) && cs && !miso;
    assign read_end = (state == ads_link_pkg::ST_READ) && xfer_done;
    assign take     = sample_valid && sample_ready;

    // ======================================================================
    // sequencing
    // ======================================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= ads_link_pkg::ST_POWERUP;
            pwr_cnt      <= '0;
            xfer_start   <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            case (state)
                ads_link_pkg::ST_POWERUP: begin
                    pwr_cnt <= pwr_cnt + 1'b1;
                    if (pwr_done) begin
                        state      <= ads_link_pkg::ST_CFG_SEND;
                        xfer_start <= 1'b1;
                    end
                end
                ads_link_pkg::ST_CFG_SEND: begin
                    if (xfer_done) begin  // rx of the config frame is stale data
                        state      <= ads_link_pkg::ST_WATCH;
                        xfer_start <= 1'b0;
                    end
                end
                ads_link_pkg::ST_WATCH: begin
                    if (drdy) begin
                        state      <= ads_link_pkg::ST_READ;
                        xfer_start <= 1'b1;
                    end
                end
                ads_link_pkg::ST_READ: begin
                    if (read_end) begin
                        xfer_start <= 1'b0;
                        if (rx_echo) begin
                            state <= ads_link_pkg::ST_WATCH;  // drop the echo
                        end else begin
                            state        <= ads_link_pkg::ST_HOLD;
                            sample_valid <= 1'b1;
                        end
                    end
                end
                ads_link_pkg::ST_HOLD: begin
                    if (take) begin
                        state        <= ads_link_pkg::ST_WATCH;
                        sample_valid <= 1'b0;
                    end
                end
                default: begin
                    state        <= ads_link_pkg::ST_POWERUP;
                    pwr_cnt      <= '0;
                    xfer_start   <= 1'b0;
                    sample_valid <= 1'b0;
                end
            endcase
        end
    end

    // ======================================================================
    // payload
    // ======================================================================

    always_ff @(posedge clk) begin
        if (pwr_done) begin
            cfg_word <= init_word;  // host codes sampled once
            tx_word  <= init_word;
        end else if (drdy) begin
            tx_word <= read_word;
        end
        if (read_end && !rx_echo) begin
            sample_data <= rx_view.conv;
        end
    end

endmodule

// File: rtl/ads_link_pkg.sv
package ads_link_pkg;

    // controller sequencing
    typedef enum logic [2:0] {
        ST_POWERUP  = 3'd0,  // power-up delay
        ST_CFG_SEND = 3'd1,  // initial config write
        ST_WATCH    = 3'd2,  // wait for miso low between frames
        ST_READ     = 3'd3,  // conversion read in progress
        ST_HOLD     = 3'd4   // result waiting for host
    } ctrl_state_e;

    // spi engine phases
    typedef enum logic [1:0] {
        PH_IDLE  = 2'd0,
        PH_LEAD  = 2'd1,  // cs setup half period
        PH_SHIFT = 2'd2,
        PH_TRAIL = 2'd3   // cs hold half period
    } spi_phase_e;

endpackage

// File: rtl/ads_reg_pkg.sv
`include "ads_cfg.svh"

package ads_reg_pkg;

    // ======================================================================
    // field codes
    // ======================================================================

    typedef enum logic [1:0] {
        NOP_NONE  = 2'b00,  // keep current config
        NOP_VALID = 2'b01   // write config
    } ads_nop_e;

    localparam logic SS_NONE         = 1'b0;  // no single-shot start
    localparam logic MODE_CONTINUOUS = 1'b0;
    localparam logic TS_ADC          = 1'b0;  // adc input rather than temp sensor
    localparam logic PULLUP_ON       = 1'b1;
    localparam logic RSV_ONE         = 1'b1;  // device expects a one here

    // ======================================================================
    // register layout
    // ======================================================================

    typedef struct packed {
        logic       ss;
        logic [2:0] mux;
        logic [2:0] pga;
        logic       mode;
        logic [2:0] dr;
        logic       ts_mode;
        logic       pull_up_en;
        ads_nop_e   nop;
        logic       reserved;
    } ads_cfg_s;

    // one spi word seen as config echo or as a conversion result
    typedef union packed {
        ads_cfg_s                         cfg;
        logic signed [`ADS_WORD_BITS-1:0] conv;
    } ads_word_u;

endpackage

// File: rtl/ads_spi.sv
`include "ads_cfg.svh"

module ads_spi (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      xfer_start,
    input  logic [`ADS_WORD_BITS-1:0] tx_word,
    output logic                      xfer_done,
    output logic [`ADS_WORD_BITS-1:0] rx_word,
    output logic                      cs,
    output logic                      sclk,
    output logic                      mosi,
    input  logic                      miso
);

    localparam int DIV_W = (`ADS_SCLK_DIV > 1) ? $clog2(`ADS_SCLK_DIV) : 1;
    localparam int BIT_W = $clog2(`ADS_WORD_BITS);
    localparam int MSB   = `ADS_WORD_BITS - 1;

    ads_link_pkg::spi_phase_e phase;

    logic [DIV_W-1:0] div_cnt;
    logic [BIT_W-1:0] bit_cnt;  // counts falling edges, wraps after the last bit
    logic [MSB:0]     shreg;

    logic div_end;
    logic start_go;
    logic last_half;
    logic rise_go;
    logic fall_go;

    // ======================================================================
    // edge timing
    // ======================================================================

    assign div_end = (div_cnt == DIV_W'(`ADS_SCLK_DIV - 1));

    // xfer_start is still high in the done cycle
    assign start_go = (phase == ads_link_pkg::PH_IDLE) && xfer_start && !xfer_done;

    // low half after the final falling edge
    assign last_half = !sclk && (bit_cnt == '0);

    assign rise_go = div_end &&
                     ((phase == ads_link_pkg::PH_LEAD) ||
                      ((phase == ads_link_pkg::PH_SHIFT) && !sclk && !last_half));

    assign fall_go = div_end && (phase == ads_link_pkg::PH_SHIFT) && sclk;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if ((phase == ads_link_pkg::PH_IDLE) || div_end) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ======================================================================
    // phase sequencing and pins
    // ======================================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase     <= ads_link_pkg::PH_IDLE;
            bit_cnt   <= '0;
            cs        <= 1'b1;
            sclk      <= 1'b0;
            mosi      <= 1'b0;
            xfer_done <= 1'b0;
        end else begin
            xfer_done <= 1'b0;
            case (phase)
                ads_link_pkg::PH_IDLE: begin
                    if (start_go) begin
                        phase   <= ads_link_pkg::PH_LEAD;
                        cs      <= 1'b0;
                        bit_cnt <= '0;
                    end
                end
                ads_link_pkg::PH_LEAD: begin
                    if (rise_go) begin
                        phase <= ads_link_pkg::PH_SHIFT;
                        sclk  <= 1'b1;
                        mosi  <= shreg[MSB];  // first bit on first rising edge
                    end
                end
                ads_link_pkg::PH_SHIFT: begin
                    if (rise_go) begin
                        sclk <= 1'b1;
                        mosi <= shreg[MSB];
                    end else if (fall_go) begin
                        sclk    <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                    end else if (div_end && last_half) begin
                        phase <= ads_link_pkg::PH_TRAIL;
                    end
                end
                ads_link_pkg::PH_TRAIL: begin
                    if (div_end) begin
                        phase     <= ads_link_pkg::PH_IDLE;
                        cs        <= 1'b1;
                        mosi      <= 1'b0;
                        xfer_done <= 1'b1;
                    end
                end
                default: begin
                    phase <= ads_link_pkg::PH_IDLE;
                    cs    <= 1'b1;
                    sclk  <= 1'b0;
                end
            endcase
        end
    end

    // ======================================================================
    // data shift
    // ======================================================================

    // tx bits leave from the top while rx bits enter at the bottom
    always_ff @(posedge clk) begin
        if (start_go) begin
            shreg <= tx_word;
        end else if (fall_go) begin
            shreg <= {shreg[MSB-1:0], miso};  // sample miso on falling sclk
        end
    end

    assign rx_word = shreg;  // holds until the next load

endmodule

// File: rtl/ads_top.sv
`include "ads_cfg.svh"

module ads_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [2:0]                       cfg_mux,
    input  logic [2:0]                       cfg_pga,
    input  logic [2:0]                       cfg_dr,
    input  logic                             miso,
    output logic                             mosi,
    output logic                             sclk,
    output logic                             cs,
    output logic signed [`ADS_WORD_BITS-1:0] sample_data,
    output logic                             sample_valid,
    input  logic                             sample_ready
);

    logic                      xfer_start;
    logic                      xfer_done;
    logic [`ADS_WORD_BITS-1:0] tx_word;
    logic [`ADS_WORD_BITS-1:0] rx_word;

    ads_ctrl ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .cfg_mux      (cfg_mux),
        .cfg_pga      (cfg_pga),
        .cfg_dr       (cfg_dr),
        .miso         (miso),   // doubles as data-ready
        .cs           (cs),
        .xfer_start   (xfer_start),
        .tx_word      (tx_word),
        .xfer_done    (xfer_done),
        .rx_word      (rx_word),
        .sample_data  (sample_data),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready)
    );

    ads_spi spi_i (
        .clk        (clk),
        .rst        (rst),
        .xfer_start (xfer_start),
        .tx_word    (tx_word),
        .xfer_done  (xfer_done),
        .rx_word    (rx_word),
        .cs         (cs),
        .sclk       (sclk),
        .mosi       (mosi),
        .miso       (miso)
    );

endmodule
